// ==== design/uart_cfg_pkg.sv ====
package uart_cfg_pkg;

    // Clock rate divided by bit rate. Kept small for fast simulation.
    localparam int CLKS_PER_BIT = 16;

    localparam int PAYLOAD_BITS = 8;  // 8N1 framing.
    localparam int BUFFER_DEPTH = 8;  // Entries per FIFO.

    localparam int BIT_CNT_W  = 4;
    localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT + 1);

    // Serial payload and FIFO entry.
    typedef logic [PAYLOAD_BITS-1:0] byte_t;

    // Index of a bit within a frame.
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

    // Clock count within one bit time.
    typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;

endpackage

// ==== design/uart_bus_pkg.sv ====
package uart_bus_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 3;

    // Bus address and data word.
    typedef logic [WORD_W-1:0] word_t;

    // Register index taken from address[4:2].
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // One bus access with plain strobes.
    typedef struct packed {
        logic  read;
        logic  write;
        word_t address;
        word_t write_data;
    } bus_req_t;

    // Register map.
    localparam reg_idx_t REG_RX_EMPTY = 3'd3;
    localparam reg_idx_t REG_RX_FULL  = 3'd4;
    localparam reg_idx_t REG_TX_EMPTY = 3'd5;
    localparam reg_idx_t REG_RX_DATA  = 3'd6;  // Only this index pops.

    // Offset of the index field within the address.
    localparam int REG_IDX_LSB = 2;

endpackage

// ==== design/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo #(
    parameter int DEPTH = uart_cfg_pkg::BUFFER_DEPTH
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  logic                pop,
    input  uart_cfg_pkg::byte_t write_data,
    output uart_cfg_pkg::byte_t read_data,
    output logic                full,
    output logic                empty
);
    import uart_cfg_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    byte_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;  // Overflow is dropped.
    assign do_pop  = pop && !empty;

    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign read_data = mem[rd_ptr];  // Head is always visible.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither.
            endcase
        end
    end

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic                clk,
    input  logic                reset,
    input  logic                rx,
    output logic                rx_valid,
    output uart_cfg_pkg::byte_t rx_data
);
    import uart_cfg_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t    state;
    logic      rx_meta;
    logic      rx_sync;
    baud_cnt_t baud_cnt;
    bit_cnt_t  bit_idx;
    byte_t     shift;
    logic      half_done;
    logic      bit_done;

    assign half_done = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));
    assign bit_done  = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

    // Two-flop synchroniser that idles high.
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                IDLE: begin
                    baud_cnt <= '0;
                    if (!rx_sync) begin
                        state <= START;  // Falling edge seen.
                    end
                end
                START: begin
                    if (half_done) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        // Low at mid-bit is a real start bit.
                        state    <= rx_sync ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        shift    <= {rx_sync, shift[PAYLOAD_BITS-1:1]};  // LSB first.
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == bit_cnt_t'(PAYLOAD_BITS - 1)) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        state    <= IDLE;
                        if (rx_sync) begin
                            rx_valid <= 1'b1;
                            rx_data  <= shift;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic                clk,
    input  logic                reset,
    input  logic                tx_start,
    input  uart_cfg_pkg::byte_t tx_data,
    output logic                tx,
    output logic                tx_busy
);
    import uart_cfg_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t    state;
    baud_cnt_t baud_cnt;
    bit_cnt_t  bit_idx;
    byte_t     shift;
    logic      bit_done;

    assign bit_done = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
    assign tx_busy  = (state != IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;
        end else begin
            baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
            case (state)
                IDLE: begin
                    baud_cnt <= '0;
                    if (tx_start) begin
                        shift <= tx_data;
                        tx    <= 1'b0;  // Start bit.
                        state <= START;
                    end
                end
                START: begin
                    if (bit_done) begin
                        tx      <= shift[0];
                        shift   <= shift >> 1;
                        bit_idx <= '0;
                        state   <= DATA;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bit_cnt_t'(PAYLOAD_BITS - 1)) begin
                            tx    <= 1'b1;  // Stop bit.
                            state <= STOP;
                        end else begin
                            tx    <= shift[0];
                            shift <= shift >> 1;
                        end
                    end
                end
                STOP: begin
                    if (bit_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== design/uart_periph.sv ====
`timescale 1ns/1ps

module uart_periph (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rx,
    input  uart_bus_pkg::bus_req_t bus,
    output logic                   tx,
    output uart_bus_pkg::word_t    read_data
);
    import uart_cfg_pkg::*;
    import uart_bus_pkg::*;

    reg_idx_t reg_idx;

    logic  tx_push;
    logic  tx_pop;
    logic  tx_full;
    logic  tx_empty;
    byte_t tx_push_data;
    byte_t tx_head;

    logic  tx_start;
    logic  tx_busy;
    byte_t tx_byte;

    logic  rx_valid;
    byte_t rx_byte;

    logic  rx_push;
    logic  rx_pop;
    logic  rx_full;
    logic  rx_empty;
    byte_t rx_push_data;
    byte_t rx_head;

    assign reg_idx = bus.address[REG_IDX_LSB +: REG_IDX_W];

    // Strobes are single-cycle pulses.
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_push  <= 1'b0;
            tx_pop   <= 1'b0;
            tx_start <= 1'b0;
            rx_push  <= 1'b0;
            rx_pop   <= 1'b0;
        end else begin
            tx_push  <= 1'b0;
            tx_pop   <= 1'b0;
            tx_start <= 1'b0;
            rx_push  <= 1'b0;
            rx_pop   <= 1'b0;

            if (bus.write && !tx_full) begin
                tx_push_data <= bus.write_data[PAYLOAD_BITS-1:0];
                tx_push      <= 1'b1;
            end

            // Skip the cycle after a launch while busy is still low.
            if (!tx_busy && !tx_empty && !tx_start) begin
                tx_start <= 1'b1;
                tx_byte  <= tx_head;
                tx_pop   <= 1'b1;
            end

            if (rx_valid && !rx_full) begin
                rx_push_data <= rx_byte;
                rx_push      <= 1'b1;
            end

            if (bus.read && reg_idx == REG_RX_DATA && !rx_empty) begin
                rx_pop <= 1'b1;
            end
        end
    end

    always_comb begin
        read_data = '0;
        case (reg_idx)
            REG_RX_EMPTY: read_data[0] = rx_empty;
            REG_RX_FULL:  read_data[0] = rx_full;
            REG_TX_EMPTY: read_data[0] = tx_empty;
            default:      read_data[PAYLOAD_BITS-1:0] = rx_head;  // Includes REG_RX_DATA.
        endcase
    end

    byte_fifo #(
        .DEPTH(BUFFER_DEPTH)
    ) tx_fifo (
        .clk        (clk),
        .reset      (reset),
        .push       (tx_push),
        .pop        (tx_pop),
        .write_data (tx_push_data),
        .read_data  (tx_head),
        .full       (tx_full),
        .empty      (tx_empty)
    );

    byte_fifo #(
        .DEPTH(BUFFER_DEPTH)
    ) rx_fifo (
        .clk        (clk),
        .reset      (reset),
        .push       (rx_push),
        .pop        (rx_pop),
        .write_data (rx_push_data),
        .read_data  (rx_head),
        .full       (rx_full),
        .empty      (rx_empty)
    );

    uart_rx uart_rx_inst (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .rx_valid (rx_valid),
        .rx_data  (rx_byte)
    );

    uart_tx uart_tx_inst (
        .clk      (clk),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_data  (tx_byte),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

// ==== tb/uart_periph_asserts.sv ====
`timescale 1ns/1ps

module uart_periph_asserts (
    input logic clk,
    input logic reset,
    input logic tx,
    input logic tx_start,
    input logic tx_busy,
    input logic tx_push,
    input logic tx_pop,
    input logic tx_full,
    input logic tx_empty,
    input logic rx_push,
    input logic rx_pop,
    input logic rx_full,
    input logic rx_empty,
    input logic rx_valid
);
    int error_count = 0;  // Read by the testbench at the end.

    task automatic note_failure(input string msg);
        error_count++;
        $error("%s", msg);
    endtask

    start_idle: assert property (@(posedge clk) disable iff (reset)
        tx_start |-> !tx_busy)
        else note_failure("Transmit launched while the transmitter is busy.");

    push_room: assert property (@(posedge clk) disable iff (reset)
        !(tx_push && tx_full) && !(rx_push && rx_full))
        else note_failure("FIFO push while full.");

    pop_data: assert property (@(posedge clk) disable iff (reset)
        !(tx_pop && tx_empty) && !(rx_pop && rx_empty))
        else note_failure("FIFO pop while empty.");

    valid_pulse: assert property (@(posedge clk) disable iff (reset)
        rx_valid |=> !rx_valid)
        else note_failure("rx_valid held longer than one cycle.");

    // Reset forces the line to idle on the next edge.
    tx_idle: assert property (@(posedge clk) reset |=> tx)
        else note_failure("tx not high during reset.");

endmodule

bind uart_periph uart_periph_asserts asserts_inst (.*);

// ==== tb/uart_periph_tb.sv ====
`timescale 1ns/1ps

module uart_periph_tb;
    import uart_cfg_pkg::*;
    import uart_bus_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_BYTES    = 20;
    localparam int NUM_DUPLEX   = 12;
    localparam int TOTAL_FRAMES = 2 * NUM_BYTES + BUFFER_DEPTH + 2 + 3 + 2 * NUM_DUPLEX;
    localparam int TIMEOUT_NS   = TOTAL_FRAMES * 10 * CLKS_PER_BIT * CLK_PERIOD * 3 + 20000;

    logic        clk = 1'b0;
    logic        reset;
    logic        rx;
    bus_req_t    bus;
    logic        tx;
    word_t       read_data;
    int unsigned lcg_state = 11;
    byte_t       exp_tx[$];
    byte_t       exp_rx[$];

    uart_periph uart_periph_inst (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .bus       (bus),
        .tx        (tx),
        .read_data (read_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;  // Upper bits are the better ones.
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "Testbench stopped on error.");
    endtask

    task automatic check(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
                                        name, actual, expected));
        end
    endtask

    task automatic read_reg(input reg_idx_t idx, output word_t data);
        @(negedge clk);
        bus.read    = 1'b1;
        bus.address = word_t'(idx) << REG_IDX_LSB;
        #1;
        data = read_data;  // Settled within the low phase.
        @(negedge clk);
        bus.read = 1'b0;  // Idle cycle keeps reads apart.
    endtask

    task automatic write_byte(input byte_t data);
        @(negedge clk);
        bus.write      = 1'b1;
        bus.write_data = word_t'(data);
        @(negedge clk);
        bus.write = 1'b0;
    endtask

    task automatic send_frame(input byte_t data, input logic stop_bit);
        logic [9:0] frame;
        int         i;
        frame = {stop_bit, data, 1'b0};
        @(negedge clk);
        for (i = 0; i < 10; i++) begin
            rx = frame[i];  // LSB first after the start bit.
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rx = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge clk);  // One idle bit.
    endtask

    task automatic read_rx_byte();
        word_t data;
        if (exp_rx.size() == 0) begin
            stop_with_failure("Tried to read a received byte that was never sent");
        end
        data = 32'd1;
        while (data[0] != 1'b0) begin
            read_reg(REG_RX_EMPTY, data);
        end
        read_reg(REG_RX_DATA, data);
        check("read_data", data, word_t'(exp_rx.pop_front()));
    endtask

    // Decodes every frame on tx against the written bytes.
    initial begin : tx_decoder
        byte_t data;
        int    i;
        forever begin
            @(negedge tx);
            repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Mid-bit.
            check("tx start bit", word_t'(tx), 0);
            for (i = 0; i < PAYLOAD_BITS; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                data[i] = tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check("tx stop bit", word_t'(tx), 1);
            if (exp_tx.size() == 0) begin
                stop_with_failure("A frame appeared on tx with no byte written for it");
            end
            check("tx data", word_t'(data), word_t'(exp_tx.pop_front()));
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        stop_with_failure("Run timed out before all tests finished");
    end

    initial begin : main
        word_t data;
        byte_t value;
        byte_t tx_value;
        int    gap;
        int    i;
        reset = 1'b1;
        rx    = 1'b1;
        bus   = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        read_reg(REG_RX_EMPTY, data);
        check("rx_empty", data, 1);
        read_reg(REG_TX_EMPTY, data);
        check("tx_empty", data, 1);
        read_reg(REG_RX_FULL, data);
        check("rx_full", data, 0);
        check("tx", word_t'(tx), 1);

        // Transmit path stays at most a FIFO's worth ahead.
        for (i = 0; i < NUM_BYTES; i++) begin
            repeat (next_rand() % 40) @(negedge clk);
            while (exp_tx.size() >= BUFFER_DEPTH) @(negedge clk);
            value = byte_t'(next_rand());
            exp_tx.push_back(value);
            write_byte(value);
        end
        while (exp_tx.size() != 0) @(negedge clk);
        read_reg(REG_TX_EMPTY, data);
        check("tx_empty", data, 1);

        for (i = 0; i < NUM_BYTES; i++) begin
            value = byte_t'(next_rand());
            exp_rx.push_back(value);
            send_frame(value, 1'b1);
            read_rx_byte();
        end
        read_reg(REG_RX_EMPTY, data);
        check("rx_empty", data, 1);

        for (i = 0; i < BUFFER_DEPTH + 2; i++) begin
            value = byte_t'(next_rand());
            if (i < BUFFER_DEPTH) begin
                exp_rx.push_back(value);  // The last two find the FIFO full.
            end
            send_frame(value, 1'b1);
        end
        read_reg(REG_RX_FULL, data);
        check("rx_full", data, 1);
        for (i = 0; i < BUFFER_DEPTH; i++) begin
            read_rx_byte();
        end
        read_reg(REG_RX_EMPTY, data);
        check("rx_empty", data, 1);

        // Bad stop bit between two good frames.
        value = byte_t'(next_rand());
        exp_rx.push_back(value);
        send_frame(value, 1'b1);
        send_frame(byte_t'(next_rand()), 1'b0);
        value = byte_t'(next_rand());
        exp_rx.push_back(value);
        send_frame(value, 1'b1);
        read_rx_byte();
        read_rx_byte();
        read_reg(REG_RX_EMPTY, data);
        check("rx_empty", data, 1);

        for (i = 0; i < NUM_DUPLEX; i++) begin
            value    = byte_t'(next_rand());
            tx_value = byte_t'(next_rand());
            gap      = next_rand() % 100;
            exp_rx.push_back(value);
            exp_tx.push_back(tx_value);
            fork
                send_frame(value, 1'b1);
                begin
                    repeat (gap) @(negedge clk);
                    write_byte(tx_value);
                end
            join
            read_rx_byte();
        end
        while (exp_tx.size() != 0) @(negedge clk);
        read_reg(REG_TX_EMPTY, data);
        check("tx_empty", data, 1);
        read_reg(REG_RX_EMPTY, data);
        check("rx_empty", data, 1);

        if (uart_periph_inst.asserts_inst.error_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stop_with_failure("Bound assertions reported errors during the run");
        end
    end

endmodule

// ==== uart_periph.f ====
design/uart_cfg_pkg.sv
design/uart_bus_pkg.sv
design/byte_fifo.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_periph.sv
tb/uart_periph_asserts.sv
tb/uart_periph_tb.sv

// ==== Bender.yml ====
package:
  name: uart_periph

sources:
  - files:
      - design/uart_cfg_pkg.sv
      - design/uart_bus_pkg.sv
      - design/byte_fifo.sv
      - design/uart_rx.sv
      - design/uart_tx.sv
      - design/uart_periph.sv
  - target: test
    files:
      - tb/uart_periph_asserts.sv
      - tb/uart_periph_tb.sv
